//--- cpu_pkg.sv
package cpu_pkg;

    localparam int unsigned xlen       = 32;
    localparam int unsigned reg_addr_w = 5;
    localparam int unsigned num_regs   = 32;

    // funct3 field of the integer ops
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_sltu    = 3'b011;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_srl_sra = 3'b101;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    localparam logic [6:0] f7_zero = 7'b0000000;
    localparam logic [6:0] f7_alt  = 7'b0100000; // sub, sra, srai

    // major opcodes still handled
    typedef enum logic [6:0] {
        op_imm = 7'b0010011,
        op_reg = 7'b0110011,
        op_lui = 7'b0110111
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_and    = 4'd2,
        alu_or     = 4'd3,
        alu_xor    = 4'd4,
        alu_sll    = 4'd5,
        alu_srl    = 4'd6,
        alu_sra    = 4'd7,
        alu_slt    = 4'd8,
        alu_sltu   = 4'd9,
        alu_pass_b = 4'd10  // lui
    } alu_op_e;

    typedef struct packed {
        alu_op_e               alu_op;
        logic [reg_addr_w-1:0] rd;
        logic [reg_addr_w-1:0] rs1;
        logic [reg_addr_w-1:0] rs2;
        logic [xlen-1:0]       imm;
        logic                  use_imm;   // operand b from imm
        logic                  writes_rd; // low for rd == x0
    } decoded_t;

    typedef struct packed {
        logic                  valid;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       data;
    } commit_t;

endpackage

//--- cpu_decode.sv
`timescale 1ns/1ps

module cpu_decode (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     inst_valid,
    input  logic [cpu_pkg::xlen-1:0] inst,
    output logic                     dec_valid,
    output cpu_pkg::decoded_t        dec,
    output logic                     illegal
);

    cpu_pkg::opcode_e  opcode;
    cpu_pkg::decoded_t dec_d;
    logic [2:0]        funct3;
    logic [6:0]        funct7;
    logic              alt;
    logic              legal;

    // funct3 plus the alternate bit to alu op, shared by both forms
    function automatic cpu_pkg::alu_op_e f3_to_alu(input logic [2:0] f3, input logic alt_sel);
        cpu_pkg::alu_op_e op;
        case (f3)
            cpu_pkg::f3_add_sub: op = alt_sel ? cpu_pkg::alu_sub : cpu_pkg::alu_add;
            cpu_pkg::f3_sll:     op = cpu_pkg::alu_sll;
            cpu_pkg::f3_slt:     op = cpu_pkg::alu_slt;
            cpu_pkg::f3_sltu:    op = cpu_pkg::alu_sltu;
            cpu_pkg::f3_xor:     op = cpu_pkg::alu_xor;
            cpu_pkg::f3_srl_sra: op = alt_sel ? cpu_pkg::alu_sra : cpu_pkg::alu_srl;
            cpu_pkg::f3_or:      op = cpu_pkg::alu_or;
            default:             op = cpu_pkg::alu_and;
        endcase
        return op;
    endfunction

    assign opcode = cpu_pkg::opcode_e'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign alt    = (funct7 == cpu_pkg::f7_alt);

    always_comb begin
        dec_d.rd        = inst[11:7];
        dec_d.rs1       = inst[19:15];
        dec_d.rs2       = inst[24:20];
        dec_d.imm       = {{20{inst[31]}}, inst[31:20]}; // I immediate
        dec_d.use_imm   = 1'b0;
        dec_d.writes_rd = (inst[11:7] != '0);
        dec_d.alu_op    = cpu_pkg::alu_add;
        legal           = 1'b0;

        case (opcode)
            cpu_pkg::op_reg: begin
                // alt funct7 only exists for sub and sra
                legal = (funct7 == cpu_pkg::f7_zero) ||
                        (alt && (funct3 == cpu_pkg::f3_add_sub ||
                                 funct3 == cpu_pkg::f3_srl_sra));
                dec_d.alu_op = f3_to_alu(funct3, alt);
            end
            cpu_pkg::op_imm: begin
                dec_d.use_imm = 1'b1;
                if (funct3 == cpu_pkg::f3_sll) begin
                    legal = (funct7 == cpu_pkg::f7_zero);
                end else if (funct3 == cpu_pkg::f3_srl_sra) begin
                    legal = (funct7 == cpu_pkg::f7_zero) || alt;
                end else begin
                    legal = 1'b1;
                end
                // no subi, so alt only picks srai
                dec_d.alu_op = f3_to_alu(funct3, alt && funct3 == cpu_pkg::f3_srl_sra);
            end
            cpu_pkg::op_lui: begin
                legal         = 1'b1;
                dec_d.use_imm = 1'b1;
                dec_d.imm     = {inst[31:12], 12'b0};
                dec_d.alu_op  = cpu_pkg::alu_pass_b;
            end
            default: begin
                legal = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dec_valid <= 1'b0;
            illegal   <= 1'b0;
        end else begin
            dec_valid <= inst_valid && legal;
            illegal   <= inst_valid && !legal;
        end
    end

    always_ff @(posedge clk) begin
        if (inst_valid && legal) begin
            dec <= dec_d;
        end
    end

endmodule

//--- cpu_execute.sv
`timescale 1ns/1ps

module cpu_execute (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           dec_valid,
    input  cpu_pkg::decoded_t              dec,
    output logic [cpu_pkg::reg_addr_w-1:0] rs1_addr,
    output logic [cpu_pkg::reg_addr_w-1:0] rs2_addr,
    input  logic [cpu_pkg::xlen-1:0]       rs1_data,
    input  logic [cpu_pkg::xlen-1:0]       rs2_data,
    output cpu_pkg::commit_t               commit
);

    logic [cpu_pkg::xlen-1:0]       op_a;
    logic [cpu_pkg::xlen-1:0]       op_b;
    logic [4:0]                     shamt;
    logic [cpu_pkg::xlen-1:0]       alu_res;
    logic                           commit_valid_q;
    logic [cpu_pkg::reg_addr_w-1:0] commit_rd_q;
    logic [cpu_pkg::xlen-1:0]       commit_data_q;

    // operand indices go straight to the register file
    assign rs1_addr = dec.rs1;
    assign rs2_addr = dec.rs2;

    assign op_a  = rs1_data;
    assign op_b  = dec.use_imm ? dec.imm : rs2_data;
    assign shamt = op_b[4:0];

    always_comb begin
        alu_res = '0;
        case (dec.alu_op)
            cpu_pkg::alu_add:    alu_res = op_a + op_b;
            cpu_pkg::alu_sub:    alu_res = op_a - op_b;
            cpu_pkg::alu_and:    alu_res = op_a & op_b;
            cpu_pkg::alu_or:     alu_res = op_a | op_b;
            cpu_pkg::alu_xor:    alu_res = op_a ^ op_b;
            cpu_pkg::alu_sll:    alu_res = op_a << shamt;
            cpu_pkg::alu_srl:    alu_res = op_a >> shamt;
            cpu_pkg::alu_sra:    alu_res = $signed(op_a) >>> shamt;
            cpu_pkg::alu_slt:    alu_res[0] = $signed(op_a) < $signed(op_b);
            cpu_pkg::alu_sltu:   alu_res[0] = op_a < op_b;
            cpu_pkg::alu_pass_b: alu_res = op_b;
            default:             alu_res = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            commit_valid_q <= 1'b0;
        end else begin
            commit_valid_q <= dec_valid && dec.writes_rd; // x0 never commits
        end
    end

    always_ff @(posedge clk) begin
        commit_rd_q   <= dec.rd;
        commit_data_q <= alu_res;
    end

    assign commit = '{
        valid: commit_valid_q,
        rd:    commit_rd_q,
        data:  commit_data_q
    };

endmodule

//--- cpu_result.sv
`timescale 1ns/1ps

module cpu_result (
    input  logic                           clk,
    input  logic                           arst_n,
    input  cpu_pkg::commit_t               commit,
    input  logic [cpu_pkg::reg_addr_w-1:0] rs1_addr,
    input  logic [cpu_pkg::reg_addr_w-1:0] rs2_addr,
    output logic [cpu_pkg::xlen-1:0]       rs1_data,
    output logic [cpu_pkg::xlen-1:0]       rs2_data,
    input  logic [cpu_pkg::reg_addr_w-1:0] dbg_addr,
    output logic [cpu_pkg::xlen-1:0]       dbg_data
);

    // x1..x31, x0 is not stored
    logic [cpu_pkg::xlen-1:0] regs [1:cpu_pkg::num_regs-1];

    function automatic logic [cpu_pkg::xlen-1:0] file_read(
        input logic [cpu_pkg::reg_addr_w-1:0] addr
    );
        logic [cpu_pkg::xlen-1:0] val;
        if (addr == '0) begin
            val = '0;
        end else begin
            val = regs[addr];
        end
        return val;
    endfunction

    // pending commit wins over the file
    function automatic logic [cpu_pkg::xlen-1:0] fwd_read(
        input logic [cpu_pkg::reg_addr_w-1:0] addr
    );
        logic [cpu_pkg::xlen-1:0] val;
        if (commit.valid && commit.rd == addr) begin
            val = commit.data;
        end else begin
            val = file_read(addr);
        end
        return val;
    endfunction

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < cpu_pkg::num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (commit.valid && commit.rd != '0) begin
            regs[commit.rd] <= commit.data;
        end
    end

    always_comb begin
        rs1_data = fwd_read(rs1_addr);
        rs2_data = fwd_read(rs2_addr);
    end

    // debug view is architectural state only
    always_comb begin
        dbg_data = file_read(dbg_addr);
    end

endmodule

//--- cpu_top.sv
`timescale 1ns/1ps

module cpu_top (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           inst_valid,
    input  logic [cpu_pkg::xlen-1:0]       inst,
    output cpu_pkg::commit_t               commit,
    output logic                           illegal,
    input  logic [cpu_pkg::reg_addr_w-1:0] dbg_addr,
    output logic [cpu_pkg::xlen-1:0]       dbg_data
);

    logic                           dec_valid;
    cpu_pkg::decoded_t              dec;
    logic [cpu_pkg::reg_addr_w-1:0] rs1_addr;
    logic [cpu_pkg::reg_addr_w-1:0] rs2_addr;
    logic [cpu_pkg::xlen-1:0]       rs1_data;
    logic [cpu_pkg::xlen-1:0]       rs2_data;

    cpu_decode i_cpu_decode (
        .clk        (clk),
        .arst_n     (arst_n),
        .inst_valid (inst_valid),
        .inst       (inst),
        .dec_valid  (dec_valid),
        .dec        (dec),
        .illegal    (illegal)
    );

    cpu_execute i_cpu_execute (
        .clk       (clk),
        .arst_n    (arst_n),
        .dec_valid (dec_valid),
        .dec       (dec),
        .rs1_addr  (rs1_addr),
        .rs2_addr  (rs2_addr),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .commit    (commit)
    );

    // register file, also forwards the commit back to execute
    cpu_result i_cpu_result (
        .clk      (clk),
        .arst_n   (arst_n),
        .commit   (commit),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .dbg_addr (dbg_addr),
        .dbg_data (dbg_data)
    );

endmodule

//--- tb_cpu.sv
`timescale 1ns/1ps

module tb_cpu;

    localparam int clk_period  = 100;
    localparam int drive_delay = 10;

    typedef struct packed {
        logic [7:0]  kind;  // I, B or R
        logic [31:0] word;
        logic [7:0]  mode;  // c commit, n none, x illegal
        logic [4:0]  rd;
        logic [31:0] value;
    } vec_t;

    typedef struct packed {
        logic [31:0] idx;
        logic [31:0] due;   // cycle count seen at the negedge
        logic [4:0]  rd;
        logic [31:0] data;
    } expect_t;

    logic                           clk;
    logic                           arst_n;
    logic                           inst_valid;
    logic [cpu_pkg::xlen-1:0]       inst;
    logic [cpu_pkg::reg_addr_w-1:0] dbg_addr;
    cpu_pkg::commit_t               commit;
    logic                           illegal;
    logic [cpu_pkg::xlen-1:0]       dbg_data;

    vec_t        vecs[$];
    string       vec_names[$];
    expect_t     commit_q[$];
    expect_t     illegal_q[$];
    int          cycle;
    logic [31:0] rng;
    bit          loaded;

    cpu_top i_cpu_top (
        .clk        (clk),
        .arst_n     (arst_n),
        .inst_valid (inst_valid),
        .inst       (inst),
        .commit     (commit),
        .illegal    (illegal),
        .dbg_addr   (dbg_addr),
        .dbg_data   (dbg_data)
    );

    initial clk = 1'b0;
    always #(clk_period / 2) clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic load_vectors();
        int          fd;
        int          code;
        int          rd;
        logic [31:0] word;
        logic [31:0] value;
        string       tok;
        string       mode_s;
        string       name;
        string       rest;
        vec_t        v;
        fd = $fopen("cpu_vectors.txt", "r");
        assert (fd != 0) else stop_with_failure("could not open cpu_vectors.txt");
        while (!$feof(fd)) begin
            code = $fscanf(fd, "%s", tok);
            if (code == 1) begin
                v = '0;
                if (tok[0] == "#") begin
                    code = $fgets(rest, fd); // skip comment line
                end else if (tok == "R") begin
                    code = $fscanf(fd, "%d %h", rd, value);
                    assert (code == 2) else stop_with_failure("malformed R line in vector file");
                    v.kind  = "R";
                    v.rd    = rd[4:0];
                    v.value = value;
                    vecs.push_back(v);
                    vec_names.push_back($sformatf("final_x%0d", rd));
                end else if (tok == "I" || tok == "B") begin
                    code = $fscanf(fd, "%h %s %d %h %s", word, mode_s, rd, value, name);
                    assert (code == 5) else stop_with_failure("malformed instruction line");
                    assert (mode_s == "c" || mode_s == "n" || mode_s == "x")
                        else stop_with_failure("unknown expect code in vector file");
                    v.kind  = tok[0];
                    v.word  = word;
                    v.mode  = mode_s[0];
                    v.rd    = rd[4:0];
                    v.value = value;
                    vecs.push_back(v);
                    vec_names.push_back(name);
                end else begin
                    stop_with_failure("unknown line type in vector file");
                end
            end
        end
        $fclose(fd);
    endtask

    // the DUT samples these at the next edge
    task automatic issue(input int idx);
        expect_t e;
        inst_valid = 1'b1;
        inst       = vecs[idx].word;
        e.idx      = idx;
        e.rd       = vecs[idx].rd;
        e.data     = vecs[idx].value;
        if (vecs[idx].mode == "c") begin
            e.due = cycle + 2;
            commit_q.push_back(e);
        end else if (vecs[idx].mode == "x") begin
            e.due = cycle + 1;
            illegal_q.push_back(e);
        end
    endtask

    task automatic check_register(input int idx);
        @(posedge clk);
        #(drive_delay);
        dbg_addr = vecs[idx].rd;
        @(negedge clk);
        assert (dbg_data === vecs[idx].value)
            else stop_with_failure($sformatf("mismatch %s: expected %h, actual %h",
                                             vec_names[idx], vecs[idx].value, dbg_data));
    endtask

    // commit and illegal are registered, so the negedge sees them settled
    always @(negedge clk) begin
        expect_t e;
        if (arst_n) begin
            assert (!$isunknown(commit.valid) && !$isunknown(illegal))
                else stop_with_failure("commit valid or illegal is unknown after reset");
            if (commit.valid) begin
                assert (commit_q.size() > 0)
                    else stop_with_failure($sformatf("commit to x%0d arrived with none expected",
                                                     commit.rd));
                e = commit_q.pop_front();
                assert (cycle == e.due)
                    else stop_with_failure($sformatf(
                        "mismatch %s: commit cycle expected %0d, actual %0d",
                        vec_names[e.idx], e.due, cycle));
                assert (commit.rd == e.rd)
                    else stop_with_failure($sformatf("mismatch %s: rd expected %0d, actual %0d",
                                                     vec_names[e.idx], e.rd, commit.rd));
                assert (commit.data === e.data)
                    else stop_with_failure($sformatf("mismatch %s: data expected %h, actual %h",
                                                     vec_names[e.idx], e.data, commit.data));
            end
            if (illegal) begin
                assert (illegal_q.size() > 0)
                    else stop_with_failure("illegal pulse arrived with no bad instruction pending");
                e = illegal_q.pop_front();
                assert (cycle == e.due)
                    else stop_with_failure($sformatf(
                        "mismatch %s: illegal cycle expected %0d, actual %0d",
                        vec_names[e.idx], e.due, cycle));
            end
        end
    end

    initial begin
        longint limit;
        wait (loaded);
        limit = (longint'(vecs.size()) * 3 + 20) * clk_period;
        #(limit);
        stop_with_failure("watchdog timeout, the simulation did not finish in time");
    end

    initial begin
        int gap;
        arst_n     = 1'b0;
        inst_valid = 1'b0;
        inst       = '0;
        dbg_addr   = '0;
        cycle      = 0;
        rng        = 32'd89;
        loaded     = 1'b0;
        load_vectors();
        loaded = 1'b1;
        repeat (5) @(posedge clk);
        #(drive_delay);
        arst_n = 1'b1;

        foreach (vecs[i]) begin
            if (vecs[i].kind != "R") begin
                gap = 0;
                if (vecs[i].kind == "I") begin
                    rng = next_random(rng);
                    gap = rng % 3;
                end
                repeat (gap) begin
                    @(posedge clk);
                    #(drive_delay);
                    inst_valid = 1'b0;
                    rng        = next_random(rng);
                    inst       = rng; // junk, valid is low
                end
                @(posedge clk);
                #(drive_delay);
                issue(i);
            end
        end
        @(posedge clk);
        #(drive_delay);
        inst_valid = 1'b0;
        repeat (3) @(posedge clk); // fixed commit latency
        assert (commit_q.size() == 0)
            else stop_with_failure("an expected commit never arrived");
        assert (illegal_q.size() == 0)
            else stop_with_failure("an expected illegal pulse never arrived");

        foreach (vecs[i]) begin
            if (vecs[i].kind == "R") begin
                check_register(i);
            end
        end

        $display("NO ERRORS");
        $finish;
    end

endmodule

//--- cpu_vectors.txt
# kind (I random gap, B back to back) inst expect (c commit, n none, x illegal) rd value name
# R index value, final register read on the debug port
I 800000B7 c 1 80000000 lui_x1
I 00500113 c 2 00000005 addi_x2
I FFD00193 c 3 FFFFFFFD addi_neg_x3
I 00310233 c 4 00000002 add_x4
I 403102B3 c 5 00000008 sub_x5
I 00317333 c 6 00000005 and_x6
I 003163B3 c 7 FFFFFFFD or_x7
I 00314433 c 8 FFFFFFF8 xor_x8
I 0021A4B3 c 9 00000001 slt_x9
I 0021B533 c 10 00000000 sltu_x10
I 002115B3 c 11 000000A0 sll_x11
I 0020D633 c 12 04000000 srl_x12
I 4020D6B3 c 13 FC000000 sra_x13
I 00311733 c 14 A0000000 sll_low5_x14
I 402007B3 c 15 FFFFFFFB sub_wrap_x15
I 00108833 c 16 00000000 add_wrap_x16
I FFF14893 c 17 FFFFFFFA xori_x17
I 0F016913 c 18 000000F5 ori_x18
I 0FF1F993 c 19 000000FD andi_x19
I FFF12A13 c 20 00000000 slti_x20
I FFF13A93 c 21 00000001 sltiu_x21
I 01F11B13 c 22 80000000 slli_x22
I 0040DB93 c 23 08000000 srli_x23
I 4040DC13 c 24 F8000000 srai_x24
I 80018C93 c 25 FFFFF7FD addi_min_x25
I 12345D37 c 26 12345000 lui_x26
I 00100D93 c 27 00000001 chain_start_x27
B 01BD8DB3 c 27 00000002 fwd_add_x27_a
B 01BD8DB3 c 27 00000004 fwd_add_x27_b
B 402D8E33 c 28 FFFFFFFF fwd_sub_x28
B 01BE0EB3 c 29 00000003 fwd_two_src_x29
B 007D8013 n 0 00000000 addi_x0
B 01D00F33 c 30 00000003 add_after_x0_x30
B 00002283 x 5 00000000 load_illegal
B 01EF0FB3 c 31 00000006 add_after_illegal_x31
I 022102B3 x 5 00000000 mul_illegal
I 40111293 x 5 00000000 slli_alt_illegal
B 00108093 c 1 80000001 addi_x1_again
B 0020C133 c 2 80000004 fwd_xor_x2
R 0 00000000
R 1 80000001
R 2 80000004
R 3 FFFFFFFD
R 4 00000002
R 5 00000008
R 6 00000005
R 7 FFFFFFFD
R 8 FFFFFFF8
R 9 00000001
R 10 00000000
R 11 000000A0
R 12 04000000
R 13 FC000000
R 14 A0000000
R 15 FFFFFFFB
R 16 00000000
R 17 FFFFFFFA
R 18 000000F5
R 19 000000FD
R 20 00000000
R 21 00000001
R 22 80000000
R 23 08000000
R 24 F8000000
R 25 FFFFF7FD
R 26 12345000
R 27 00000004
R 28 FFFFFFFF
R 29 00000003
R 30 00000003
R 31 00000006

//--- compile.f
cpu_pkg.sv
cpu_decode.sv
cpu_execute.sv
cpu_result.sv
cpu_top.sv
tb_cpu.sv

//--- Bender.yml
package:
  name: cpu_pipe

sources:
  - files:
      - cpu_pkg.sv
      - cpu_decode.sv
      - cpu_execute.sv
      - cpu_result.sv
      - cpu_top.sv
  - target: test
    files:
      - tb_cpu.sv
